/* Bender.yml */
package:
  name: branchPredictUnit

sources:
  - bpuPkg.sv
  - branchTargetBuffer.sv
  - fetchPcGen.sv
  - bpuCsr.sv
  - branchPredictUnit.sv
  - target: test
    files:
      - tbClock.sv
      - branchPredictUnit_tb.sv

/* bpuCsr.sv */
`timescale 1ns/10ps

module bpuCsr
    import bpuPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wbCyc,
    input  logic                    wbStb,
    input  logic                    wbWe,
    input  logic [WB_ADR_BITS-1:0]  wbAdr,
    input  logic [WB_DATA_BITS-1:0] wbDatW,
    output logic [WB_DATA_BITS-1:0] wbDatR,
    output logic                    wbAck,
    input  logic                    initBusy,
    input  logic                    fetchValid,
    input  logic                    predValid,
    output logic                    enable,
    output logic                    flush
);

    logic                    access;
    logic                    cntClear;
    logic [WB_DATA_BITS-1:0] rdData;
    logic [WB_DATA_BITS-1:0] lookups;
    logic [WB_DATA_BITS-1:0] hits;

    // A new request is seen once the previous acknowledge has gone
    assign access   = wbCyc && wbStb && !wbAck;
    assign cntClear = access && wbWe && CsrAddr'(wbAdr) == CSR_LOOKUPS;

    always_comb begin
        case (CsrAddr'(wbAdr))
            CSR_CTRL:    rdData = WB_DATA_BITS'(enable);
            CSR_STATUS:  rdData = WB_DATA_BITS'(initBusy);
            CSR_LOOKUPS: rdData = lookups;
            CSR_HITS:    rdData = hits;
            default:     rdData = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            wbDatR <= rdData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wbAck  <= 1'b0;
            enable <= 1'b1;
            flush  <= 1'b0;
        end else begin
            wbAck <= access;
            flush <= 1'b0;
            if (access && wbWe && CsrAddr'(wbAdr) == CSR_CTRL) begin
                enable <= wbDatW[0];
                flush  <= wbDatW[1];
            end
        end
    end

    // Statistics, a write to the lookup counter clears both
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lookups <= '0;
            hits    <= '0;
        end else if (cntClear) begin
            lookups <= '0;
            hits    <= '0;
        end else if (fetchValid) begin
            lookups <= lookups + 1'b1;
            if (predValid) begin
                hits <= hits + 1'b1;
            end
        end
    end

    // The master holds its request until the acknowledge
    assert property (@(posedge clk) disable iff (rst)
        wbAck |-> wbCyc && wbStb && $past(wbCyc && wbStb));

endmodule

/* bpuPkg.sv */
package bpuPkg;

    // Fetch addresses count halfwords, so a 32-bit byte address
    // loses its lowest bit
    localparam int PC_WIDTH = 31;

    // An 8-byte fetch line holds four halfwords
    localparam int FETCH_OFF_BITS = 2;

    // Direct-mapped branch target buffer geometry
    localparam int BTB_ENTRIES = 64;
    localparam int BTB_IDX_BITS = $clog2(BTB_ENTRIES);

    // The tag comes from the PC bits just above the index
    localparam int BTB_TAG_BITS = 10;

    // Wishbone register port
    localparam int WB_ADR_BITS = 2;
    localparam int WB_DATA_BITS = 32;

    // Kinds of control transfer a BTB entry can describe
    typedef enum logic [1:0] {
        BT_BRANCH = 2'd0,
        BT_JUMP   = 2'd1,
        BT_CALL   = 2'd2,
        BT_RETURN = 2'd3
    } BranchType;

    // Word addresses of the control and status registers
    typedef enum logic [WB_ADR_BITS-1:0] {
        CSR_CTRL    = 2'd0,
        CSR_STATUS  = 2'd1,
        CSR_LOOKUPS = 2'd2,
        CSR_HITS    = 2'd3
    } CsrAddr;

endpackage

/* branchPredictUnit.f */
bpuPkg.sv
branchTargetBuffer.sv
fetchPcGen.sv
bpuCsr.sv
branchPredictUnit.sv
tbClock.sv
branchPredictUnit_tb.sv

/* branchPredictUnit.sv */
`timescale 1ns/10ps

module branchPredictUnit
    import bpuPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wbCyc,
    input  logic                      wbStb,
    input  logic                      wbWe,
    input  logic [WB_ADR_BITS-1:0]    wbAdr,
    input  logic [WB_DATA_BITS-1:0]   wbDatW,
    output logic [WB_DATA_BITS-1:0]   wbDatR,
    output logic                      wbAck,
    input  logic                      updValid,
    input  logic                      updClean,
    input  logic                      updMultiple,
    input  logic [FETCH_OFF_BITS-1:0] updMultipleOffs,
    input  logic [FETCH_OFF_BITS-1:0] updFetchStartOffs,
    input  logic [31:0]               updSrc,
    input  logic [31:0]               updDst,
    input  BranchType                 updBtype,
    input  logic                      updCompr,
    input  logic                      fetchStall,
    input  logic                      redirectValid,
    input  logic [PC_WIDTH-1:0]       redirectPc,
    output logic                      fetchValid,
    output logic [PC_WIDTH-1:0]       fetchPc,
    output logic                      predValid,
    output logic                      predTaken,
    output logic                      predCompr,
    output logic                      predMultiple,
    output logic [PC_WIDTH-1:0]       predDst,
    output BranchType                 predBtype,
    output logic [FETCH_OFF_BITS-1:0] predOffs
);

    logic                enable;
    logic                flush;
    logic                initBusy;
    logic                lookupValid;
    logic [PC_WIDTH-1:0] lookupPc;

    branchTargetBuffer btb0 (
        .clk               (clk),
        .rst               (rst),
        .flush             (flush),
        .lookupValid       (lookupValid),
        .lookupPc          (lookupPc),
        .updValid          (updValid),
        .updClean          (updClean),
        .updMultiple       (updMultiple),
        .updMultipleOffs   (updMultipleOffs),
        .updFetchStartOffs (updFetchStartOffs),
        .updSrc            (updSrc),
        .updDst            (updDst),
        .updBtype          (updBtype),
        .updCompr          (updCompr),
        .predValid         (predValid),
        .predTaken         (predTaken),
        .predCompr         (predCompr),
        .predMultiple      (predMultiple),
        .predDst           (predDst),
        .predBtype         (predBtype),
        .predOffs          (predOffs),
        .initBusy          (initBusy)
    );

    fetchPcGen pcGen0 (
        .clk           (clk),
        .rst           (rst),
        .initBusy      (initBusy),
        .enable        (enable),
        .fetchStall    (fetchStall),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .predValid     (predValid),
        .predTaken     (predTaken),
        .predDst       (predDst),
        .lookupValid   (lookupValid),
        .lookupPc      (lookupPc),
        .fetchValid    (fetchValid),
        .fetchPc       (fetchPc)
    );

    bpuCsr csr0 (
        .clk        (clk),
        .rst        (rst),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbDatW     (wbDatW),
        .wbDatR     (wbDatR),
        .wbAck      (wbAck),
        .initBusy   (initBusy),
        .fetchValid (fetchValid),
        .predValid  (predValid),
        .enable     (enable),
        .flush      (flush)
    );

endmodule

/* branchPredictUnit_tb.sv */
`timescale 1ns/10ps

module branchPredictUnit_tb
    import bpuPkg::*;
();

    // About 1600 cycles of tests, the limit leaves a margin of 2.5
    localparam int CYCLE_LIMIT = 4000;

    typedef struct {
        BranchType           btype;
        logic                compr;
        logic [PC_WIDTH-1:0] dst;
        logic [BTB_TAG_BITS-1:0] tag;
        logic [FETCH_OFF_BITS-1:0] offs;
    } ModelEntry;

    logic clk, rst;
    logic wbCyc, wbStb, wbWe;
    logic [WB_ADR_BITS-1:0] wbAdr;
    logic [WB_DATA_BITS-1:0] wbDatW, wbDatR;
    logic wbAck;
    logic updValid, updClean, updMultiple, updCompr;
    logic [FETCH_OFF_BITS-1:0] updMultipleOffs, updFetchStartOffs, predOffs;
    logic [31:0] updSrc, updDst;
    BranchType updBtype, predBtype;
    logic fetchStall, redirectValid, fetchValid;
    logic [PC_WIDTH-1:0] redirectPc, fetchPc, predDst;
    logic predValid, predTaken, predCompr, predMultiple;

    // Reference model state
    ModelEntry btb[int];
    bit multFlag[int];
    ModelEntry rdE;
    bit rdHas, rdMult, armed, setMultValid, slotValid, mAck, mEnable, mFlush;
    int clrIdx, setMultIdx, valueErrors, protoErrors, cycles;
    logic [PC_WIDTH-1:0] rdPc, curPc, slotPc;
    logic [WB_DATA_BITS-1:0] mDatR, lookups, hits;
    logic [PC_WIDTH-FETCH_OFF_BITS-1:0] poolLine [8];

    tbClock clkGen0 (.clk(clk), .rst(rst));

    branchPredictUnit dut0 (.*);

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("Errors: %0d value mismatches, %0d protocol failures",
                     valueErrors, protoErrors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic checkPc(string name, logic [PC_WIDTH-1:0] exp, logic [PC_WIDTH-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkType(string name, BranchType exp, BranchType act);
        if (act !== exp) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s expected %s got %s", $time, name,
                     exp.name(), act.name());
        end
    endtask

    task automatic checkWord(string name, logic [WB_DATA_BITS-1:0] exp,
                             logic [WB_DATA_BITS-1:0] act);
        if (act !== exp) begin
            valueErrors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // A hit needs a stored branch of the same tag at or after the fetch offset
    function automatic bit modelHit();
        return armed && rdHas && rdE.tag == rdPc[BTB_IDX_BITS +: BTB_TAG_BITS]
            && rdE.offs >= rdPc[FETCH_OFF_BITS-1:0];
    endfunction

    function automatic bit isTaken(BranchType t);
        return t == BT_JUMP || t == BT_CALL;
    endfunction

    task automatic resetModel();
        btb.delete();
        multFlag.delete();
        {rdHas, rdMult, armed, setMultValid, slotValid, mAck, mFlush} = '0;
        mEnable = 1'b1;
        clrIdx = 0;
        curPc = '0;
        slotPc = '0;
        lookups = '0;
        hits = '0;
    endtask

    // Advances the model over the rising edge that just passed
    task automatic stepModel();
        bit busy, hit, fv, follow, acc;
        int ui, wi, ri;
        ModelEntry ne;
        logic [PC_WIDTH-1:0] tgt;
        busy = clrIdx < BTB_ENTRIES;
        hit = modelHit();
        fv = slotValid && !fetchStall && !busy;
        follow = fv && mEnable && hit && isTaken(rdE.btype);
        // Target of the slot on the outputs, before this edge's lookup replaces it
        tgt = rdE.dst;
        acc = wbCyc && wbStb && !mAck;
        if (!busy && !fetchStall) begin
            ri = curPc[BTB_IDX_BITS-1:0];
            rdHas = btb.exists(ri);
            if (rdHas) rdE = btb[ri];
            rdMult = multFlag.exists(ri);
            rdPc = curPc;
            armed = 1'b1;
        end else if (busy) begin
            armed = 1'b0;
        end
        ui = {updSrc[BTB_IDX_BITS:FETCH_OFF_BITS+1], updFetchStartOffs};
        wi = (updMultiple && !updClean)
           ? {updSrc[BTB_IDX_BITS:FETCH_OFF_BITS+1], updMultipleOffs} : ui;
        ne.btype = updBtype;
        ne.compr = updCompr;
        ne.dst = updDst[PC_WIDTH:1];
        ne.tag = updSrc[BTB_IDX_BITS+1 +: BTB_TAG_BITS];
        ne.offs = updSrc[FETCH_OFF_BITS:1];
        if (busy) begin
            btb.delete(clrIdx);
            multFlag.delete(clrIdx);
        end else if (updValid && updClean) begin
            btb.delete(ui);
        end else if (updValid) begin
            btb[wi] = ne;
            multFlag.delete(wi);
        end else if (setMultValid) begin
            multFlag[setMultIdx] = 1'b1;
        end
        if (acc) begin
            case (CsrAddr'(wbAdr))
                CSR_CTRL:    mDatR = WB_DATA_BITS'(mEnable);
                CSR_STATUS:  mDatR = WB_DATA_BITS'(busy);
                CSR_LOOKUPS: mDatR = lookups;
                default:     mDatR = hits;
            endcase
        end
        if (acc && wbWe && CsrAddr'(wbAdr) == CSR_LOOKUPS) begin
            lookups = '0;
            hits = '0;
        end else if (fv) begin
            lookups++;
            if (hit) hits++;
        end
        if (mFlush) begin
            clrIdx = 0;
            setMultValid = 1'b0;
        end else if (busy) begin
            clrIdx++;
        end else if (updValid) begin
            if (!updClean && updMultiple) begin
                setMultValid = 1'b1;
                setMultIdx = ui;
            end
        end else begin
            setMultValid = 1'b0;
        end
        if (redirectValid) begin
            curPc = redirectPc;
            slotValid = 1'b0;
        end else if (busy) begin
            // A slot dropped by the sweep is fetched again afterwards
            if (slotValid) curPc = slotPc;
            slotValid = 1'b0;
        end else if (!fetchStall) begin
            slotPc = curPc;
            slotValid = !follow;
            curPc = follow ? tgt
                  : {curPc[PC_WIDTH-1:FETCH_OFF_BITS] + 1'b1, {FETCH_OFF_BITS{1'b0}}};
        end
        mAck = acc;
        mFlush = 1'b0;
        if (acc && wbWe && CsrAddr'(wbAdr) == CSR_CTRL) begin
            mEnable = wbDatW[0];
            mFlush = wbDatW[1];
        end
    endtask

    task automatic compareOutputs();
        bit hit, fv;
        hit = modelHit();
        fv = slotValid && !fetchStall && clrIdx >= BTB_ENTRIES;
        checkBit("fetchValid", fv, fetchValid);
        if (fv) checkPc("fetchPc", slotPc, fetchPc);
        checkBit("predValid", hit, predValid);
        checkBit("predTaken", hit && isTaken(rdE.btype), predTaken);
        if (hit) begin
            checkPc("predDst", rdE.dst, predDst);
            checkType("predBtype", rdE.btype, predBtype);
            checkPc("predOffs", PC_WIDTH'(rdE.offs), PC_WIDTH'(predOffs));
            checkBit("predCompr", rdE.compr, predCompr);
            checkBit("predMultiple", rdMult, predMultiple);
        end
        checkBit("wbAck", mAck, wbAck);
        if (mAck) checkWord("wbDatR", mDatR, wbDatR);
    endtask

    // One clock, inputs change after the outputs are compared
    task automatic tick();
        @(negedge clk);
        if (rst) resetModel();
        else stepModel();
        compareOutputs();
    endtask

    task automatic idleInputs();
        updValid = 1'b0;
        updClean = 1'b0;
        updMultiple = 1'b0;
        redirectValid = 1'b0;
        fetchStall = 1'b0;
    endtask

    task automatic wbAccess(logic we, CsrAddr adr, logic [WB_DATA_BITS-1:0] wdata,
                            output logic [WB_DATA_BITS-1:0] rdata);
        int n;
        {wbCyc, wbStb, wbWe, wbAdr, wbDatW} = {2'b11, we, adr, wdata};
        n = 0;
        do begin
            tick();
            n++;
        end while (!wbAck && n < 20);
        if (!wbAck) begin
            protoErrors++;
            $display("Wishbone access to %s was never acknowledged", adr.name());
        end
        rdata = wbDatR;
        // The request stays up through the edge that samples the acknowledge
        tick();
        {wbCyc, wbStb, wbWe} = 3'b000;
    endtask

    task automatic waitIdle();
        logic [WB_DATA_BITS-1:0] d;
        int n;
        n = 0;
        do begin
            wbAccess(1'b0, CSR_STATUS, '0, d);
            n++;
        end while (d[0] && n < 40);
        if (d[0]) begin
            protoErrors++;
            $display("BTB stayed busy clearing its entries");
        end
    endtask

    task automatic runRandom(int n, int updPct, int stallPct, int redirPct);
        int off;
        repeat (n) begin
            tick();
            off = $urandom % 4;
            updValid = ($urandom % 100) < updPct;
            updClean = ($urandom % 8) == 0;
            updMultiple = ($urandom % 5) == 0;
            updSrc = {poolLine[$urandom % 8], FETCH_OFF_BITS'(off), 1'b0};
            updFetchStartOffs = FETCH_OFF_BITS'($urandom % (off + 1));
            updMultipleOffs = FETCH_OFF_BITS'($urandom % (off + 1));
            updDst = {poolLine[$urandom % 8], FETCH_OFF_BITS'($urandom), 1'b0};
            updBtype = BranchType'($urandom % 4);
            updCompr = 1'($urandom % 2);
            fetchStall = ($urandom % 100) < stallPct;
            redirectValid = ($urandom % 100) < redirPct;
            redirectPc = {poolLine[$urandom % 8], FETCH_OFF_BITS'($urandom)};
        end
        tick();
        idleInputs();
    endtask

    initial begin
        logic [WB_DATA_BITS-1:0] d;
        void'($urandom(4));
        idleInputs();
        {wbCyc, wbStb, wbWe, wbAdr, wbDatW} = '0;
        {updMultipleOffs, updFetchStartOffs, updSrc, updDst, updCompr} = '0;
        updBtype = BT_BRANCH;
        redirectPc = '0;
        // Few tags over a few indexes, so lines collide and hit often
        foreach (poolLine[i]) begin
            poolLine[i] = {2'($urandom % 4), 4'($urandom)};
        end
        tick();
        while (rst) tick();
        wbAccess(1'b0, CSR_STATUS, '0, d);
        checkBit("status busy after reset", 1'b1, d[0]);
        waitIdle();
        repeat (20) tick();
        runRandom(500, 40, 10, 5);
        wbAccess(1'b1, CSR_CTRL, 32'h0, d);
        runRandom(200, 30, 10, 5);
        wbAccess(1'b1, CSR_CTRL, 32'h1, d);
        runRandom(400, 20, 15, 4);
        wbAccess(1'b0, CSR_LOOKUPS, '0, d);
        wbAccess(1'b0, CSR_HITS, '0, d);
        wbAccess(1'b1, CSR_CTRL, 32'h3, d);
        tick();
        wbAccess(1'b0, CSR_STATUS, '0, d);
        checkBit("status busy after flush", 1'b1, d[0]);
        waitIdle();
        runRandom(100, 0, 10, 10);
        wbAccess(1'b1, CSR_LOOKUPS, '0, d);
        wbAccess(1'b0, CSR_LOOKUPS, '0, d);
        wbAccess(1'b0, CSR_HITS, '0, d);
        repeat (5) tick();
        $display("Errors: %0d value mismatches, %0d protocol failures",
                 valueErrors, protoErrors);
        if (valueErrors + protoErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* branchTargetBuffer.sv */
`timescale 1ns/10ps

module branchTargetBuffer
    import bpuPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      lookupValid,
    input  logic [PC_WIDTH-1:0]       lookupPc,
    input  logic                      updValid,
    input  logic                      updClean,
    input  logic                      updMultiple,
    input  logic [FETCH_OFF_BITS-1:0] updMultipleOffs,
    input  logic [FETCH_OFF_BITS-1:0] updFetchStartOffs,
    input  logic [31:0]               updSrc,
    input  logic [31:0]               updDst,
    input  BranchType                 updBtype,
    input  logic                      updCompr,
    output logic                      predValid,
    output logic                      predTaken,
    output logic                      predCompr,
    output logic                      predMultiple,
    output logic [PC_WIDTH-1:0]       predDst,
    output BranchType                 predBtype,
    output logic [FETCH_OFF_BITS-1:0] predOffs,
    output logic                      initBusy
);

    typedef struct packed {
        logic                      valid;
        BranchType                 btype;
        logic                      compr;
        logic [PC_WIDTH-1:0]       dst;
        logic [BTB_TAG_BITS-1:0]   tag;
        logic [FETCH_OFF_BITS-1:0] offs;
    } BtbEntry;

    BtbEntry entryMem [BTB_ENTRIES];
    logic    multMem  [BTB_ENTRIES];

    // Clear sweep counter, the top bit set means the sweep is done
    logic [BTB_IDX_BITS:0]   clrIdx;

    // Pending write of the multiple flag for an earlier branch
    logic                    setMultValid;
    logic [BTB_IDX_BITS-1:0] setMultIdx;

    logic [BTB_IDX_BITS-1:0] updIdx;
    logic [BTB_IDX_BITS-1:0] wrIdx;
    BtbEntry                 updEntry;

    logic                    entWe;
    logic [BTB_IDX_BITS-1:0] entIdx;
    BtbEntry                 entData;
    logic                    multWe;
    logic [BTB_IDX_BITS-1:0] multIdx;
    logic                    multData;

    BtbEntry                 rdEntry;
    logic                    rdMult;
    logic [PC_WIDTH-1:0]     rdPc;
    logic                    rdArmed;
    logic                    hit;

    assign initBusy = !clrIdx[BTB_IDX_BITS];

    // Entries are keyed by the line of the source and the offset where
    // the fetch into that line started
    assign updIdx = {updSrc[BTB_IDX_BITS:FETCH_OFF_BITS+1], updFetchStartOffs};

    // A second branch in the same line lands in the slot after the first one
    assign wrIdx = (updMultiple && !updClean)
                 ? {updIdx[BTB_IDX_BITS-1:FETCH_OFF_BITS], updMultipleOffs}
                 : updIdx;

    always_comb begin
        updEntry.valid = 1'b1;
        updEntry.btype = updBtype;
        updEntry.compr = updCompr;
        updEntry.dst   = updDst[PC_WIDTH:1];
        updEntry.tag   = updSrc[BTB_IDX_BITS+1 +: BTB_TAG_BITS];
        updEntry.offs  = updSrc[FETCH_OFF_BITS:1];
    end

    // One write port per array, shared by the sweep, the updates and the
    // deferred multiple flag
    always_comb begin
        entWe    = 1'b0;
        entIdx   = wrIdx;
        entData  = updEntry;
        multWe   = 1'b0;
        multIdx  = wrIdx;
        multData = 1'b0;
        if (initBusy) begin
            entWe   = 1'b1;
            entIdx  = clrIdx[BTB_IDX_BITS-1:0];
            entData = '0;
            multWe  = 1'b1;
            multIdx = clrIdx[BTB_IDX_BITS-1:0];
        end else if (updValid) begin
            entWe = 1'b1;
            if (updClean) begin
                entData = '0;
            end else begin
                multWe = 1'b1;
            end
        end else if (setMultValid) begin
            multWe   = 1'b1;
            multIdx  = setMultIdx;
            multData = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (entWe) begin
            entryMem[entIdx] <= entData;
        end
        if (multWe) begin
            multMem[multIdx] <= multData;
        end
    end

    // Synchronous read, the tag check follows the register
    always_ff @(posedge clk) begin
        if (lookupValid) begin
            rdEntry <= entryMem[lookupPc[BTB_IDX_BITS-1:0]];
            rdMult  <= multMem[lookupPc[BTB_IDX_BITS-1:0]];
            rdPc    <= lookupPc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdArmed <= 1'b0;
        end else if (initBusy) begin
            rdArmed <= 1'b0;
        end else if (lookupValid) begin
            rdArmed <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clrIdx       <= '0;
            setMultValid <= 1'b0;
            setMultIdx   <= '0;
        end else if (flush) begin
            clrIdx       <= '0;
            setMultValid <= 1'b0;
        end else if (initBusy) begin
            clrIdx <= clrIdx + 1'b1;
        end else if (updValid) begin
            if (!updClean && updMultiple) begin
                setMultValid <= 1'b1;
                setMultIdx   <= updIdx;
            end
        end else if (setMultValid) begin
            setMultValid <= 1'b0;
        end
    end

    // Branches earlier in the line than the fetch PC do not count
    assign hit = rdArmed && rdEntry.valid
              && rdEntry.tag == rdPc[BTB_IDX_BITS +: BTB_TAG_BITS]
              && rdEntry.offs >= rdPc[FETCH_OFF_BITS-1:0];

    // Only unconditional transfers are followed
    assign predValid    = hit;
    assign predTaken    = hit && (rdEntry.btype == BT_JUMP || rdEntry.btype == BT_CALL);
    assign predCompr    = hit && rdEntry.compr;
    assign predMultiple = hit && rdMult;
    assign predDst      = hit ? rdEntry.dst : '0;
    assign predBtype    = hit ? rdEntry.btype : BT_BRANCH;
    assign predOffs     = hit ? rdEntry.offs : '0;

    // The back end never reports a branch before the slot it is stored in
    assert property (@(posedge clk) disable iff (rst)
        updValid && !updClean && !initBusy
        |-> updSrc[FETCH_OFF_BITS:1] >= wrIdx[FETCH_OFF_BITS-1:0]);

    // Busy has been high for a whole sweep before it drops
    assert property (@(posedge clk) disable iff (rst)
        $fell(initBusy) |-> $past(initBusy, BTB_ENTRIES));

endmodule

/* fetchPcGen.sv */
`timescale 1ns/10ps

module fetchPcGen
    import bpuPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                initBusy,
    input  logic                enable,
    input  logic                fetchStall,
    input  logic                redirectValid,
    input  logic [PC_WIDTH-1:0] redirectPc,
    input  logic                predValid,
    input  logic                predTaken,
    input  logic [PC_WIDTH-1:0] predDst,
    output logic                lookupValid,
    output logic [PC_WIDTH-1:0] lookupPc,
    output logic                fetchValid,
    output logic [PC_WIDTH-1:0] fetchPc
);

    // PC being looked up in this cycle
    logic [PC_WIDTH-1:0] curPc;

    // Lookup issued last cycle, its prediction is on the BTB outputs now
    logic [PC_WIDTH-1:0] slotPc;
    logic                slotValid;

    logic [PC_WIDTH-1:0] seqPc;
    logic                follow;

    // While stalled the BTB keeps its last read, so the slot simply waits
    assign lookupValid = !initBusy && !fetchStall;
    assign lookupPc    = curPc;

    assign fetchValid = slotValid && !fetchStall && !initBusy;
    assign fetchPc    = slotPc;

    assign follow = fetchValid && enable && predValid && predTaken;

    // Next line start
    assign seqPc = {curPc[PC_WIDTH-1:FETCH_OFF_BITS] + 1'b1, {FETCH_OFF_BITS{1'b0}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            curPc     <= '0;
            slotPc    <= '0;
            slotValid <= 1'b0;
        end else if (redirectValid) begin
            // Whatever was looked up this cycle is on the wrong path
            curPc     <= redirectPc;
            slotValid <= 1'b0;
        end else if (initBusy) begin
            // Replay the slot dropped by a flush once the sweep is over
            if (slotValid) begin
                curPc <= slotPc;
            end
            slotValid <= 1'b0;
        end else if (!fetchStall) begin
            slotPc <= curPc;
            if (follow) begin
                // The lookup issued next to the taken slot becomes a bubble
                curPc     <= predDst;
                slotValid <= 1'b0;
            end else begin
                curPc     <= seqPc;
                slotValid <= 1'b1;
            end
        end
    end

    // A fetched slot is the PC looked up just before it, unless it waited out a stall
    assert property (@(posedge clk) disable iff (rst)
        fetchValid && !$past(fetchStall) |-> $past(lookupValid) && fetchPc == $past(lookupPc));

endmodule

/* tbClock.sv */
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset covers ten rising edges and is released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule
